/* test/linear_vectors.txt */
// Per set: 4 weight rows, 1 bias, 8 input rows, 8 expected output rows
// Each word is element 3, 2, 1, 0 from left to right, Q8.8 each
0000_0000_0000_0100
0000_0040_FF80_0080
0020_0000_0200_FF00
0000_0000_4000_4000
0000_0100_FFC0_0080
0000_0000_0000_0100
0007_0005_0003_0001
0000_0000_FFFD_FFFF
0000_0000_7FFF_7FFF
0000_0000_8000_8000
0100_0100_0100_0100
FFF9_0003_0000_0000
0010_FFFF_0040_FF80
4000_0000_0040_0180
0100_0105_FFC0_0081
FF00_00FB_FFC1_007F
7FFF_7FFF_FFC0_7FFF
8000_8100_FFC0_8080
7FFF_0220_0000_0180
0000_00FF_FFC0_0080
F000_0202_FF5F_0000
0000_0000_0100_0000
0000_FF00_0000_0000
0080_0080_0080_0080
0300_0000_0000_0000
0040_0000_0080_FF00
0400_0300_0200_0100
FFFF_0003_0002_0001
FFFE_FFFF_FFFF_FFFF
4E20_0000_0000_0000
0000_8000_8000_0000
B1E0_0000_0000_0000
0000_0000_0000_0007
0100_0000_0100_0000
0C40_0500_FD80_0100
003D_0002_007D_FF02
003A_FFFD_0081_FEFF
7FFF_2710_0080_FF00
0040_8000_7FFF_8000
8000_D8F0_0080_FF00
0040_0003_0080_FF00
0340_0100_0080_0000

/* sources.f */
rtl/linear_pkg.sv
rtl/linear_param_store.sv
rtl/linear_dot_array.sv
rtl/linear_bias_cast.sv
rtl/linear_skid_buffer.sv
rtl/fixed_linear_top.sv
test/fixed_linear_properties.sv
test/fixed_linear_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fixed-point linear layer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module fixed_linear_tb \
  -o fixed_linear_sim

./obj_dir/fixed_linear_sim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0

/* test/fixed_linear_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_linear_tb;

  import linear_pkg::*;

  localparam int RESET_CYCLES   = 10;
  localparam int SET_WORDS      = 21;
  localparam int VEC_WORDS      = 2 * SET_WORDS;
  localparam int ROWS_PER_SET   = 8;
  localparam int PIPE_LATENCY   = 4;
  // Parameter beats of two loads, three input passes and their outputs
  localparam int TOTAL_BEATS    = 2 * (OUT_FEATURES + 1) + 6 * ROWS_PER_SET;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 20 + RESET_CYCLES;

  // Stream selectors for the send task
  localparam int PORT_WEIGHT = 0;
  localparam int PORT_BIAS   = 1;
  localparam int PORT_DATA   = 2;

  logic     clk;
  logic     i_reset;
  in_row_t  i_weight_row;
  logic     i_weight_valid;
  logic     o_weight_ready;
  out_row_t i_bias;
  logic     i_bias_valid;
  logic     o_bias_ready;
  in_row_t  i_data;
  logic     i_data_valid;
  logic     o_data_ready;
  out_row_t o_data_out;
  logic     o_data_out_valid;
  logic     i_data_out_ready = 1'b1;

  logic [63:0] vec_mem [VEC_WORDS];
  out_row_t    exp_rows [3 * ROWS_PER_SET];

  int cycle = 0;
  int exp_count = 0;
  int out_seen = 0;
  int test_out_base = 0;
  int first_out_edge = 0;
  int mismatch_count = 0;
  int check_errors = 0;
  int test_count = 0;
  int failed_tests = 0;
  int last_accept_edge = 0;
  bit random_ready = 1'b0;

  fixed_linear_top UUT (
    .clk              (clk),
    .i_reset          (i_reset),
    .i_weight_row     (i_weight_row),
    .i_weight_valid   (i_weight_valid),
    .o_weight_ready   (o_weight_ready),
    .i_bias           (i_bias),
    .i_bias_valid     (i_bias_valid),
    .o_bias_ready     (o_bias_ready),
    .i_data           (i_data),
    .i_data_valid     (i_data_valid),
    .o_data_ready     (o_data_ready),
    .o_data_out       (o_data_out),
    .o_data_out_valid (o_data_out_valid),
    .i_data_out_ready (i_data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // Collects output rows and draws the output ready on the falling edge
  always @(negedge clk) begin
    logic [31:0] draw;
    draw = $urandom;
    if (i_reset || !random_ready) begin
      i_data_out_ready = 1'b1;
    end else begin
      i_data_out_ready = draw[0];
    end
    if (!i_reset && o_data_out_valid && i_data_out_ready) begin
      if (out_seen >= exp_count) begin
        $display("unexpected output row %h at time %0t", o_data_out, $time);
        mismatch_count++;
      end else begin
        if (out_seen == test_out_base) begin
          first_out_edge = cycle + 1;
        end
        if (o_data_out !== exp_rows[out_seen]) begin
          $display("mismatch at time %0t: row %0d got %h expected %h", $time,
                   out_seen - test_out_base, o_data_out, exp_rows[out_seen]);
          mismatch_count++;
        end
      end
      out_seen++;
    end
  end

  function automatic int total_errors();
    return check_errors + mismatch_count;
  endfunction

  function automatic logic port_ready(input int port);
    case (port)
      PORT_WEIGHT: return o_weight_ready;
      PORT_BIAS:   return o_bias_ready;
      default:     return o_data_ready;
    endcase
  endfunction

  task automatic check_bit(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("mismatch at time %0t: %s is %b, expected %b", $time, what, actual, expected);
      check_errors++;
    end
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(negedge clk);
      i_weight_valid = 1'b0;
      i_bias_valid   = 1'b0;
      i_data_valid   = 1'b0;
    end
  endtask

  // Returns right after the rising edge that moved the beat
  task automatic send_beat(input int port, input logic [63:0] value);
    @(negedge clk);
    case (port)
      PORT_WEIGHT: begin
        i_weight_row   = value;
        i_weight_valid = 1'b1;
      end
      PORT_BIAS: begin
        i_bias       = value;
        i_bias_valid = 1'b1;
      end
      default: begin
        i_data       = value;
        i_data_valid = 1'b1;
      end
    endcase
    while (!port_ready(port)) @(negedge clk);
    last_accept_edge = cycle + 1;
    @(posedge clk);
  endtask

  task automatic load_params(input int set);
    int base;
    base = set * SET_WORDS;
    for (int j = 0; j < OUT_FEATURES; j++) begin
      send_beat(PORT_WEIGHT, vec_mem[base + j]);
      idle_cycles(1);
      check_bit(o_data_ready, 1'b0, "o_data_ready while loading weights");
    end
    send_beat(PORT_BIAS, vec_mem[base + OUT_FEATURES]);
    idle_cycles(1);
    check_bit(o_bias_ready, 1'b0, "o_bias_ready after bias");
    check_bit(o_data_ready, 1'b1, "o_data_ready after load");
  endtask

  // Feeds one set of input rows and waits for all of its outputs
  task automatic run_rows(input int set, input int max_gap);
    int base;
    int gap;
    int first_accept;
    base = set * SET_WORDS + OUT_FEATURES + 1;
    first_accept = 0;
    test_out_base = out_seen;
    for (int i = 0; i < ROWS_PER_SET; i++) begin
      exp_rows[exp_count + i] = vec_mem[base + ROWS_PER_SET + i];
    end
    exp_count = exp_count + ROWS_PER_SET;
    for (int i = 0; i < ROWS_PER_SET; i++) begin
      send_beat(PORT_DATA, vec_mem[base + i]);
      if (i == 0) begin
        first_accept = last_accept_edge;
      end
      gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
      if (gap > 0) begin
        idle_cycles(gap);
      end
    end
    idle_cycles(1);
    while (out_seen < exp_count) @(negedge clk);
    repeat (8) @(negedge clk);
    if (out_seen != exp_count) begin
      $display("error: %0d output rows seen, expected %0d", out_seen, exp_count);
      check_errors++;
    end
    if (!random_ready && (first_out_edge - first_accept != PIPE_LATENCY)) begin
      $display("mismatch at time %0t: first output after %0d cycles, expected %0d",
               $time, first_out_edge - first_accept, PIPE_LATENCY);
      check_errors++;
    end
  endtask

  task automatic report_test(input string name, input int start_errors);
    int found;
    found = total_errors() - start_errors;
    test_count++;
    if (found != 0) begin
      failed_tests++;
      $display("test %0d %s: failed with %0d errors", test_count, name, found);
    end else begin
      $display("test %0d %s: ok", test_count, name);
    end
  endtask

  initial begin
    int start_errors;
    void'($urandom(32'h66614ff1));
    i_reset        = 1'b1;
    i_weight_row   = '0;
    i_weight_valid = 1'b0;
    i_bias         = '0;
    i_bias_valid   = 1'b0;
    i_data         = '0;
    i_data_valid   = 1'b0;
    $readmemh("test/linear_vectors.txt", vec_mem);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;

    // Reset state and load gating
    start_errors = total_errors();
    check_bit(o_data_out_valid, 1'b0, "o_data_out_valid after reset");
    check_bit(o_data_ready, 1'b0, "o_data_ready after reset");
    check_bit(o_weight_ready, 1'b1, "o_weight_ready after reset");
    check_bit(o_bias_ready, 1'b0, "o_bias_ready after reset");
    load_params(0);
    report_test("reset and parameter load", start_errors);

    // Rounding and saturation rows with the output always ready
    start_errors = total_errors();
    random_ready = 1'b0;
    run_rows(0, 0);
    report_test("set one streaming with latency", start_errors);

    start_errors = total_errors();
    random_ready = 1'b1;
    run_rows(0, 0);
    report_test("set one under back-pressure", start_errors);

    // Reload replaces weights and bias
    start_errors = total_errors();
    load_params(1);
    run_rows(1, 2);
    report_test("reload with set two", start_errors);

    $display("tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, total_errors());
    if (total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/fixed_linear_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_linear_properties (
  input wire logic                  clk,
  input wire logic                  i_reset,
  input wire linear_pkg::in_row_t   i_weight_row,
  input wire logic                  i_weight_valid,
  input wire logic                  o_weight_ready,
  input wire linear_pkg::out_row_t  i_bias,
  input wire logic                  i_bias_valid,
  input wire logic                  o_bias_ready,
  input wire linear_pkg::in_row_t   i_data,
  input wire logic                  i_data_valid,
  input wire logic                  o_data_ready,
  input wire linear_pkg::out_row_t  o_data_out,
  input wire logic                  o_data_out_valid,
  input wire logic                  i_data_out_ready,
  input wire logic                  i_loaded
);

  // Stalled beats keep valid and data
  weight_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_weight_valid && !o_weight_ready |=> i_weight_valid && $stable(i_weight_row))
    else $error("weight beat changed while stalled");

  bias_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_bias_valid && !o_bias_ready |=> i_bias_valid && $stable(i_bias))
    else $error("bias beat changed while stalled");

  data_hold: assert property (@(posedge clk) disable iff (i_reset)
    i_data_valid && !o_data_ready |=> i_data_valid && $stable(i_data))
    else $error("input row changed while stalled");

  out_hold: assert property (@(posedge clk) disable iff (i_reset)
    o_data_out_valid && !i_data_out_ready |=> o_data_out_valid && $stable(o_data_out))
    else $error("output row changed while stalled");

  reset_quiet: assert property (@(posedge clk)
    i_reset |=> !o_data_out_valid && !o_data_ready)
    else $error("outputs active right after reset");

  ready_needs_params: assert property (@(posedge clk) disable iff (i_reset)
    !i_loaded |-> !o_data_ready)
    else $error("input ready without a loaded parameter set");

endmodule

bind fixed_linear_top fixed_linear_properties u_properties (
  .clk              (clk),
  .i_reset          (i_reset),
  .i_weight_row     (i_weight_row),
  .i_weight_valid   (i_weight_valid),
  .o_weight_ready   (o_weight_ready),
  .i_bias           (i_bias),
  .i_bias_valid     (i_bias_valid),
  .o_bias_ready     (o_bias_ready),
  .i_data           (i_data),
  .i_data_valid     (i_data_valid),
  .o_data_ready     (o_data_ready),
  .o_data_out       (o_data_out),
  .o_data_out_valid (o_data_out_valid),
  .i_data_out_ready (i_data_out_ready),
  .i_loaded         (loaded)
);

`default_nettype wire

/* rtl/fixed_linear_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fixed_linear_top (
  input  wire logic                  clk,
  input  wire logic                  i_reset,

  input  wire linear_pkg::in_row_t   i_weight_row,
  input  wire logic                  i_weight_valid,
  output logic                       o_weight_ready,

  input  wire linear_pkg::out_row_t  i_bias,
  input  wire logic                  i_bias_valid,
  output logic                       o_bias_ready,

  input  wire linear_pkg::in_row_t   i_data,
  input  wire logic                  i_data_valid,
  output logic                       o_data_ready,

  output linear_pkg::out_row_t       o_data_out,
  output logic                       o_data_out_valid,
  input  wire logic                  i_data_out_ready
);

  import linear_pkg::*;

  // Parameters held for the datapath
  in_row_t [OUT_FEATURES-1:0] weights;
  out_row_t                   bias;
  logic                       loaded;

  // Dot array to bias cast
  acc_row_t acc;
  logic     acc_valid;
  logic     acc_ready;

  // Bias cast to output slice
  out_row_t row;
  logic     row_valid;
  logic     row_ready;

  linear_param_store u_param_store (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_weight_row   (i_weight_row),
    .i_weight_valid (i_weight_valid),
    .o_weight_ready (o_weight_ready),
    .i_bias         (i_bias),
    .i_bias_valid   (i_bias_valid),
    .o_bias_ready   (o_bias_ready),
    .o_weights      (weights),
    .o_bias         (bias),
    .o_loaded       (loaded)
  );

  linear_dot_array u_dot_array (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_data       (i_data),
    .i_data_valid (i_data_valid),
    .o_data_ready (o_data_ready),
    .i_loaded     (loaded),
    .i_weights    (weights),
    .o_acc        (acc),
    .o_acc_valid  (acc_valid),
    .i_acc_ready  (acc_ready)
  );

  linear_bias_cast u_bias_cast (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_acc       (acc),
    .i_acc_valid (acc_valid),
    .o_acc_ready (acc_ready),
    .i_bias      (bias),
    .o_row       (row),
    .o_row_valid (row_valid),
    .i_row_ready (row_ready)
  );

  linear_skid_buffer u_skid_buffer (
    .clk         (clk),
    .i_reset     (i_reset),
    .i_row       (row),
    .i_row_valid (row_valid),
    .o_row_ready (row_ready),
    .o_row       (o_data_out),
    .o_row_valid (o_data_out_valid),
    .i_row_ready (i_data_out_ready)
  );

endmodule

`default_nettype wire

/* rtl/linear_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_skid_buffer (
  input  wire logic                  clk,
  input  wire logic                  i_reset,

  input  wire linear_pkg::out_row_t  i_row,
  input  wire logic                  i_row_valid,
  output logic                       o_row_ready,

  output linear_pkg::out_row_t       o_row,
  output logic                       o_row_valid,
  input  wire logic                  i_row_ready
);

  import linear_pkg::*;

  out_row_t skid_row;
  logic     skid_valid;
  logic     in_take;
  logic     out_take;
  logic     main_open;

  // Upstream only sees the skid state, never i_row_ready
  assign o_row_ready = !skid_valid;

  assign in_take   = i_row_valid && o_row_ready;
  assign out_take  = o_row_valid && i_row_ready;
  assign main_open = !o_row_valid || i_row_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_row_valid <= 1'b0;
      skid_valid  <= 1'b0;
    end else if (skid_valid) begin
      // Skid entry moves to the main register once the output drains
      if (out_take) begin
        skid_valid <= 1'b0;
      end
    end else if (main_open) begin
      o_row_valid <= i_row_valid;
    end else if (in_take) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (skid_valid) begin
      if (out_take) begin
        o_row <= skid_row;
      end
    end else if (in_take && main_open) begin
      o_row <= i_row;
    end
  end

  // Catches the beat that arrives while the main register is stalled
  always_ff @(posedge clk) begin
    if (in_take && !main_open) begin
      skid_row <= i_row;
    end
  end

endmodule

`default_nettype wire

/* rtl/linear_bias_cast.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_bias_cast (
  input  wire logic                  clk,
  input  wire logic                  i_reset,

  input  wire linear_pkg::acc_row_t  i_acc,
  input  wire logic                  i_acc_valid,
  output logic                       o_acc_ready,

  input  wire linear_pkg::out_row_t  i_bias,

  output linear_pkg::out_row_t       o_row,
  output logic                       o_row_valid,
  input  wire logic                  i_row_ready
);

  import linear_pkg::*;

  data_t cast_val [OUT_FEATURES];
  logic  row_load;

  assign o_acc_ready = !o_row_valid || i_row_ready;
  assign row_load    = i_acc_valid && o_acc_ready;

  // Bias add, floor to FRAC_WIDTH fraction bits, then clamp
  always_comb begin
    acc_t bias_aligned;
    acc_t sum;
    acc_t shifted;
    for (int j = 0; j < OUT_FEATURES; j++) begin
      // Bias has FRAC_WIDTH fraction bits, products have twice that
      bias_aligned = acc_t'(data_t'(i_bias[j*DATA_WIDTH +: DATA_WIDTH])) <<< FRAC_WIDTH;
      sum          = acc_t'(i_acc[j*ACC_WIDTH +: ACC_WIDTH]) + bias_aligned;
      // Arithmetic shift rounds toward minus infinity
      shifted      = sum >>> FRAC_WIDTH;
      if (shifted > acc_t'(DATA_MAX)) begin
        cast_val[j] = DATA_MAX;
      end else if (shifted < acc_t'(DATA_MIN)) begin
        cast_val[j] = DATA_MIN;
      end else begin
        cast_val[j] = shifted[DATA_WIDTH-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_row_valid <= 1'b0;
    end else if (o_acc_ready) begin
      o_row_valid <= i_acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (row_load) begin
      for (int j = 0; j < OUT_FEATURES; j++) begin
        o_row[j*DATA_WIDTH +: DATA_WIDTH] <= cast_val[j];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/linear_dot_array.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_dot_array (
  input  wire logic                                            clk,
  input  wire logic                                            i_reset,

  input  wire linear_pkg::in_row_t                             i_data,
  input  wire logic                                            i_data_valid,
  output logic                                                 o_data_ready,
  input  wire logic                                            i_loaded,

  input  wire linear_pkg::in_row_t [linear_pkg::OUT_FEATURES-1:0] i_weights,

  output linear_pkg::acc_row_t                                 o_acc,
  output logic                                                 o_acc_valid,
  input  wire logic                                            i_acc_ready
);

  import linear_pkg::*;

  // Stage one holds every product W[j][k] * x[k]
  prod_t [OUT_FEATURES-1:0][IN_FEATURES-1:0] prod_q;
  logic                                      s1_valid;
  logic                                      s1_ready;
  logic                                      s1_load;

  // Stage two holds one sum per output feature
  acc_t acc_sum [OUT_FEATURES];
  logic s2_ready;
  logic s2_load;

  // Each stage takes a beat when empty or when it is draining
  assign s2_ready = !o_acc_valid || i_acc_ready;
  assign s1_ready = !s1_valid || s2_ready;

  // Inputs wait until a full parameter set is present
  assign o_data_ready = i_loaded && s1_ready;
  assign s1_load      = i_data_valid && o_data_ready;
  assign s2_load      = s1_valid && s2_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      s1_valid <= 1'b0;
    end else if (s1_ready) begin
      s1_valid <= i_data_valid && i_loaded;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) begin
      for (int j = 0; j < OUT_FEATURES; j++) begin
        for (int k = 0; k < IN_FEATURES; k++) begin
          prod_q[j][k] <= data_t'(i_data[k*DATA_WIDTH +: DATA_WIDTH]) *
                          data_t'(i_weights[j][k*DATA_WIDTH +: DATA_WIDTH]);
        end
      end
    end
  end

  // Adder tree, exact in ACC_WIDTH bits
  always_comb begin
    for (int j = 0; j < OUT_FEATURES; j++) begin
      acc_sum[j] = '0;
      for (int k = 0; k < IN_FEATURES; k++) begin
        acc_sum[j] = acc_sum[j] + acc_t'($signed(prod_q[j][k]));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_acc_valid <= 1'b0;
    end else if (s2_ready) begin
      o_acc_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_load) begin
      for (int j = 0; j < OUT_FEATURES; j++) begin
        o_acc[j*ACC_WIDTH +: ACC_WIDTH] <= acc_sum[j];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/linear_param_store.sv */
`timescale 1ns/1ps
`default_nettype none

module linear_param_store (
  input  wire logic                                            clk,
  input  wire logic                                            i_reset,

  input  wire linear_pkg::in_row_t                             i_weight_row,
  input  wire logic                                            i_weight_valid,
  output logic                                                 o_weight_ready,

  input  wire linear_pkg::out_row_t                            i_bias,
  input  wire logic                                            i_bias_valid,
  output logic                                                 o_bias_ready,

  output linear_pkg::in_row_t [linear_pkg::OUT_FEATURES-1:0]   o_weights,
  output linear_pkg::out_row_t                                 o_bias,
  output logic                                                 o_loaded
);

  import linear_pkg::*;

  load_state_t              state;
  logic [ROW_IDX_WIDTH-1:0] row_cnt;

  logic weight_take;
  logic bias_take;

  // Weight rows are accepted everywhere except while waiting on the bias
  assign o_weight_ready = (state != LOAD_BIAS);
  assign o_bias_ready   = (state == LOAD_BIAS);
  assign o_loaded       = (state == LOADED);

  assign weight_take = i_weight_valid && o_weight_ready;
  assign bias_take   = i_bias_valid && o_bias_ready;

  // Loader FSM and row counter
  always_ff @(posedge clk) begin
    if (i_reset) begin
      state   <= LOAD_WEIGHTS;
      row_cnt <= '0;
    end else begin
      case (state)
        LOAD_WEIGHTS: begin
          if (weight_take) begin
            if (row_cnt == ROW_IDX_WIDTH'(OUT_FEATURES - 1)) begin
              row_cnt <= '0;
              state   <= LOAD_BIAS;
            end else begin
              row_cnt <= row_cnt + 1'b1;
            end
          end
        end
        LOAD_BIAS: begin
          if (bias_take) begin
            state <= LOADED;
          end
        end
        LOADED: begin
          // A new weight beat restarts the load, this beat becomes row 0
          if (weight_take) begin
            row_cnt <= ROW_IDX_WIDTH'(1);
            state   <= LOAD_WEIGHTS;
          end
        end
        default: begin
          state   <= LOAD_WEIGHTS;
          row_cnt <= '0;
        end
      endcase
    end
  end

  // Weight register file, row index is zero on a reload
  always_ff @(posedge clk) begin
    if (weight_take) begin
      o_weights[row_cnt] <= i_weight_row;
    end
  end

  always_ff @(posedge clk) begin
    if (bias_take) begin
      o_bias <= i_bias;
    end
  end

endmodule

`default_nettype wire

/* rtl/linear_pkg.sv */
`default_nettype none

package linear_pkg;

  // Layer dimensions
  localparam int IN_FEATURES  = 4;
  localparam int OUT_FEATURES = 4;

  // Data, weights, bias and output share one Q8.8 format
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_WIDTH = 8;

  // A full product keeps twice the fraction bits
  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  // Sum of IN_FEATURES products grows by log2 of the term count
  localparam int ACC_WIDTH = PROD_WIDTH + $clog2(IN_FEATURES);

  // Counter width for the weight row index
  localparam int ROW_IDX_WIDTH = $clog2(OUT_FEATURES);

  typedef logic signed [DATA_WIDTH-1:0] data_t;
  typedef logic signed [PROD_WIDTH-1:0] prod_t;
  typedef logic signed [ACC_WIDTH-1:0]  acc_t;

  // Element k sits at bits 16k+15 down to 16k
  typedef logic [IN_FEATURES*DATA_WIDTH-1:0]  in_row_t;
  typedef logic [OUT_FEATURES*DATA_WIDTH-1:0] out_row_t;
  typedef logic [OUT_FEATURES*ACC_WIDTH-1:0]  acc_row_t;

  // Saturation limits of the output format
  localparam data_t DATA_MAX = data_t'({1'b0, {(DATA_WIDTH-1){1'b1}}});
  localparam data_t DATA_MIN = data_t'({1'b1, {(DATA_WIDTH-1){1'b0}}});

  typedef enum logic [1:0] {
    LOAD_WEIGHTS,
    LOAD_BIAS,
    LOADED
  } load_state_t;

endpackage

`default_nettype wire
